// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "All tests passed" $(LOG) || (echo "Simulation reported failure, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: ahb_decoder.sv
/* AHB-Lite address decoder and read mux */

module ahb_decoder import soc_pkg::*; (
  input  logic              clk,
  input  logic              RSTn,
  input  logic [ADDR_W-1:0] haddr,
  input  logic [1:0]        htrans,
  output logic              ram_sel,
  output logic              led_sel,
  output logic              uart_sel,
  input  logic [DATA_W-1:0] ram_rdata,
  input  logic [DATA_W-1:0] led_rdata,
  input  logic [DATA_W-1:0] uart_rdata,
  output logic [DATA_W-1:0] hrdata
);

  slave_e addr_slv;
  slave_e data_slv;
  logic   valid;

  assign valid = (htrans == NONSEQ) || (htrans == SEQ);

  // Region match on the upper address bits
  always_comb begin
    if (haddr[ADDR_W-1:12] == RAM_BASE[ADDR_W-1:12]) addr_slv = SLV_RAM;
    else if (haddr[ADDR_W-1:12] == LED_BASE[ADDR_W-1:12]) addr_slv = SLV_LED;
    else if (haddr[ADDR_W-1:12] == UART_BASE[ADDR_W-1:12]) addr_slv = SLV_UART;
    else addr_slv = SLV_NONE;
  end

  assign ram_sel  = (addr_slv == SLV_RAM);
  assign led_sel  = (addr_slv == SLV_LED);
  assign uart_sel = (addr_slv == SLV_UART);

  // Slave owning the data phase
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) data_slv <= SLV_NONE;
    else data_slv <= valid ? addr_slv : SLV_NONE;
  end

  always_comb begin
    case (data_slv)
      SLV_RAM:  hrdata = ram_rdata;
      SLV_LED:  hrdata = led_rdata;
      SLV_UART: hrdata = uart_rdata;
      default:  hrdata = '0;
    endcase
  end

endmodule

// File: ahb_led.sv
/* AHB-Lite LED register */

module ahb_led import soc_pkg::*; (
  input  logic              clk,
  input  logic              RSTn,
  input  logic              sel,
  input  logic [1:0]        htrans,
  input  logic              hwrite,
  input  logic [DATA_W-1:0] hwdata,
  output logic [DATA_W-1:0] rdata,
  output logic [7:0]        led
);

  logic wr_pend;

  // Write seen in the address phase
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) wr_pend <= 1'b0;
    else wr_pend <= sel && hwrite && ((htrans == NONSEQ) || (htrans == SEQ));
  end

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) led <= 8'h00;
    else if (wr_pend) led <= hwdata[7:0];
  end

  assign rdata = {{(DATA_W-8){1'b0}}, led};

endmodule

// File: ahb_ram.sv
/* AHB-Lite block RAM */

module ahb_ram import soc_pkg::*; #(
  parameter int RAM_AW = 10
) (
  input  logic              clk,
  input  logic              RSTn,
  input  logic              sel,
  input  logic [ADDR_W-1:0] haddr,
  input  logic [1:0]        htrans,
  input  logic [2:0]        hsize,
  input  logic              hwrite,
  input  logic [DATA_W-1:0] hwdata,
  output logic [DATA_W-1:0] rdata
);

  logic [DATA_W-1:0] mem [0:2**RAM_AW-1];
  logic              valid;
  logic [3:0]        strb;
  logic [3:0]        wr_strb;
  logic [RAM_AW-1:0] wr_addr;

  assign valid = sel && ((htrans == NONSEQ) || (htrans == SEQ));

  // Byte lanes from size and low address bits
  always_comb begin
    case (hsize)
      BYTE:    strb = 4'b0001 << haddr[1:0];
      HALF:    strb = haddr[1] ? 4'b1100 : 4'b0011;
      default: strb = 4'b1111;
    endcase
  end

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) wr_strb <= 4'b0000;
    else if (valid && hwrite) wr_strb <= strb;
    else wr_strb <= 4'b0000;
  end

  always_ff @(posedge clk) begin
    if (valid && hwrite) wr_addr <= haddr[RAM_AW+1:2];
  end

  // ------------------------------------------------------------
  // Memory array
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (wr_strb[i]) mem[wr_addr][8*i +: 8] <= hwdata[8*i +: 8];
    end
  end

  // Read at the address phase, word out in the data phase
  always_ff @(posedge clk) begin
    if (valid && !hwrite) rdata <= mem[haddr[RAM_AW+1:2]];
  end

endmodule

// File: ahb_uart.sv
/* AHB-Lite UART register bridge */

module ahb_uart import soc_pkg::*; (
  input  logic              clk,
  input  logic              RSTn,
  input  logic              sel,
  input  logic [ADDR_W-1:0] haddr,
  input  logic [1:0]        htrans,
  input  logic              hwrite,
  input  logic [DATA_W-1:0] hwdata,
  output logic [DATA_W-1:0] rdata,
  output logic              tx_start,
  output logic [7:0]        tx_byte,
  input  logic [7:0]        rx_byte,
  input  logic              tx_busy
);

  logic        valid;
  logic        wr_q;
  logic [11:0] ofs_q;

  assign valid = sel && ((htrans == NONSEQ) || (htrans == SEQ));

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) wr_q <= 1'b0;
    else wr_q <= valid && hwrite;
  end

  always_ff @(posedge clk) begin
    if (valid) ofs_q <= haddr[11:0];
  end

  // Transmit kick in the write data phase
  assign tx_start = wr_q && (ofs_q == UART_DATA_OFS);
  assign tx_byte  = hwdata[7:0];

  // Register readback
  always_comb begin
    case (ofs_q)
      UART_DATA_OFS: rdata = {{(DATA_W-8){1'b0}}, rx_byte};
      UART_STAT_OFS: rdata = {{(DATA_W-1){1'b0}}, tx_busy};
      default:       rdata = '0;
    endcase
  end

endmodule

// File: compile.f
soc_pkg.sv
ahb_decoder.sv
ahb_ram.sv
ahb_led.sv
ahb_uart.sv
uart_baud.sv
uart_tx.sv
uart_rx.sv
soc_top.sv
tb_soc.sv

// File: soc_pkg.sv
/* SoC bus definitions */

package soc_pkg;

  // ------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // AHB-Lite transfer types and sizes
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  // ------------------------------------------------------------
  // Address map, 4 KB regions matched on bits 31..12
  // ------------------------------------------------------------
  typedef enum logic [1:0] {SLV_RAM, SLV_LED, SLV_UART, SLV_NONE} slave_e;

  localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] LED_BASE  = 32'h4000_0000;
  localparam logic [ADDR_W-1:0] UART_BASE = 32'h4000_1000;

  // UART register offsets
  localparam logic [11:0] UART_DATA_OFS = 12'h000;
  localparam logic [11:0] UART_STAT_OFS = 12'h004;

endpackage

// File: soc_top.sv
/* Bus-side microcontroller top */

module soc_top import soc_pkg::*; #(
  parameter int RAM_AW   = 10,
  parameter int BAUD_DIV = 347
) (
  input  logic              clk,
  input  logic              RSTn,
  input  logic [ADDR_W-1:0] haddr,
  input  logic [1:0]        htrans,
  input  logic [2:0]        hsize,
  input  logic              hwrite,
  input  logic [DATA_W-1:0] hwdata,
  output logic [DATA_W-1:0] hrdata,
  output logic              hready,
  output logic              hresp,
  output logic [7:0]        led,
  input  logic              rxd,
  output logic              txd,
  output logic              uart_irq
);

  logic              ram_sel;
  logic              led_sel;
  logic              uart_sel;
  logic [DATA_W-1:0] ram_rdata;
  logic [DATA_W-1:0] led_rdata;
  logic [DATA_W-1:0] uart_rdata;
  logic              tx_start;
  logic [7:0]        tx_byte;
  logic              tx_busy;
  logic              tx_req;
  logic [7:0]        rx_byte;
  logic              rx_req;
  logic              tick;

  // Zero wait states, always OKAY
  assign hready = 1'b1;
  assign hresp  = 1'b0;

  // ------------------------------------------------------------
  // Bus fabric and slaves
  // ------------------------------------------------------------
  ahb_decoder u_ahb_decoder (
    .clk        (clk),
    .RSTn       (RSTn),
    .haddr      (haddr),
    .htrans     (htrans),
    .ram_sel    (ram_sel),
    .led_sel    (led_sel),
    .uart_sel   (uart_sel),
    .ram_rdata  (ram_rdata),
    .led_rdata  (led_rdata),
    .uart_rdata (uart_rdata),
    .hrdata     (hrdata)
  );

  ahb_ram #(
    .RAM_AW (RAM_AW)
  ) u_ahb_ram (
    .clk    (clk),
    .RSTn   (RSTn),
    .sel    (ram_sel),
    .haddr  (haddr),
    .htrans (htrans),
    .hsize  (hsize),
    .hwrite (hwrite),
    .hwdata (hwdata),
    .rdata  (ram_rdata)
  );

  ahb_led u_ahb_led (
    .clk    (clk),
    .RSTn   (RSTn),
    .sel    (led_sel),
    .htrans (htrans),
    .hwrite (hwrite),
    .hwdata (hwdata),
    .rdata  (led_rdata),
    .led    (led)
  );

  ahb_uart u_ahb_uart (
    .clk      (clk),
    .RSTn     (RSTn),
    .sel      (uart_sel),
    .haddr    (haddr),
    .htrans   (htrans),
    .hwrite   (hwrite),
    .hwdata   (hwdata),
    .rdata    (uart_rdata),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .rx_byte  (rx_byte),
    .tx_busy  (tx_busy)
  );

  // ------------------------------------------------------------
  // UART core, one baud counter for both directions
  // ------------------------------------------------------------
  uart_baud #(
    .BAUD_DIV (BAUD_DIV)
  ) u_uart_baud (
    .clk    (clk),
    .RSTn   (RSTn),
    .tx_req (tx_req),
    .rx_req (rx_req),
    .tick   (tick)
  );

  uart_tx u_uart_tx (
    .clk      (clk),
    .RSTn     (RSTn),
    .tick     (tick),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx_req   (tx_req),
    .txd      (txd)
  );

  uart_rx u_uart_rx (
    .clk     (clk),
    .RSTn    (RSTn),
    .rxd     (rxd),
    .tick    (tick),
    .rx_req  (rx_req),
    .rx_byte (rx_byte),
    .rx_done (uart_irq)
  );

endmodule

// File: tb_soc.sv
/* Bus-side SoC testbench */

module tb_soc import soc_pkg::*; ();

  localparam int BAUD_DIV     = 16;
  localparam int RESET_CYCLES = 10;

  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [2:0]  size;
    logic [31:0] data;
    logic [31:0] exp;
  } row_t;

  logic        clk;
  logic        RSTn;
  logic [31:0] haddr;
  logic [1:0]  htrans;
  logic [2:0]  hsize;
  logic        hwrite;
  logic [31:0] hwdata;
  logic [31:0] hrdata;
  logic        hready;
  logic        hresp;
  logic [7:0]  led;
  logic        rxd;
  logic        txd;
  logic        uart_irq;

  row_t        rows[$];
  logic [31:0] ram_model [logic [9:0]];
  logic [7:0]  led_model;
  int          errors;
  int          checks;
  int          irq_cnt;
  int          cycles;
  int          cycle_limit;
  logic [7:0]  tx_val;
  logic [7:0]  rx_val;

  soc_top #(
    .RAM_AW   (10),
    .BAUD_DIV (BAUD_DIV)
  ) u_soc_top (
    .clk      (clk),
    .RSTn     (RSTn),
    .haddr    (haddr),
    .htrans   (htrans),
    .hsize    (hsize),
    .hwrite   (hwrite),
    .hwdata   (hwdata),
    .hrdata   (hrdata),
    .hready   (hready),
    .hresp    (hresp),
    .led      (led),
    .rxd      (rxd),
    .txd      (txd),
    .uart_irq (uart_irq)
  );

  always #10 clk = ~clk;

  // ------------------------------------------------------------
  // Reference model of the address map and byte lanes
  // ------------------------------------------------------------
  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] addr,
                                              input logic [2:0] size, input logic [31:0] data);
    int          nbytes;
    int          first;
    logic [31:0] res;
    // A transfer covers 2**size bytes from its aligned start
    nbytes = 1 << size;
    first  = (int'(addr[1:0]) / nbytes) * nbytes;
    res    = old;
    for (int i = 0; i < 4; i++) begin
      if (i >= first && i < first + nbytes) res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] expect_read(input logic [31:0] addr);
    if (addr[31:12] == RAM_BASE[31:12])
      return ram_model.exists(addr[11:2]) ? ram_model[addr[11:2]] : 32'h0;
    else if (addr[31:12] == LED_BASE[31:12])
      return {24'h0, led_model};
    return 32'h0;
  endfunction

  task automatic add_write(input logic [31:0] addr, input logic [2:0] size,
                           input logic [31:0] data);
    logic [31:0] old;
    if (addr[31:12] == RAM_BASE[31:12]) begin
      old = ram_model.exists(addr[11:2]) ? ram_model[addr[11:2]] : 32'h0;
      ram_model[addr[11:2]] = merge_lanes(old, addr, size, data);
    end else if (addr[31:12] == LED_BASE[31:12]) begin
      led_model = data[7:0];
    end
    rows.push_back('{1'b1, addr, size, data, 32'h0});
  endtask

  task automatic add_read(input logic [31:0] addr);
    rows.push_back('{1'b0, addr, WORD, 32'h0, expect_read(addr)});
  endtask

  task automatic build_table();
    logic [31:0] ram_addr [4];
    ram_addr = '{32'h2000_0000, 32'h2000_0010, 32'h2000_0400, 32'h2000_0FFC};
    // Unmapped region and LED reset value
    add_read(32'h3000_0000);
    add_read(LED_BASE);
    add_write(32'h5000_0008, WORD, $urandom);
    add_read(32'h5000_0008);
    for (int i = 0; i < 4; i++) add_write(ram_addr[i], WORD, $urandom);
    for (int i = 0; i < 4; i++) add_read(ram_addr[i]);
    // Byte and halfword lanes over full words
    add_write(32'h2000_0020, WORD, $urandom);
    add_write(32'h2000_0021, BYTE, $urandom);
    add_write(32'h2000_0022, HALF, $urandom);
    add_read(32'h2000_0020);
    add_write(32'h2000_0024, WORD, $urandom);
    add_write(32'h2000_0027, BYTE, $urandom);
    add_write(32'h2000_0024, HALF, $urandom);
    add_read(32'h2000_0024);
    add_write(32'h2000_0028, WORD, $urandom);
    add_write(32'h2000_0028, BYTE, $urandom);
    add_write(32'h2000_002A, BYTE, $urandom);
    add_read(32'h2000_0028);
    add_write(LED_BASE, WORD, $urandom);
    add_read(LED_BASE);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // ------------------------------------------------------------
  // Bus master, serial driver and serial monitor
  // ------------------------------------------------------------
  task automatic bus_xfer(input logic wr, input logic [31:0] addr, input logic [2:0] size,
                          input logic [31:0] data, input logic [31:0] exp);
    @(posedge clk);
    haddr  <= addr;
    htrans <= NONSEQ;
    hsize  <= size;
    hwrite <= wr;
    @(posedge clk);
    htrans <= IDLE;
    hwrite <= 1'b0;
    hwdata <= wr ? data : 32'h0;
    @(negedge clk);
    if (!wr) check_val($sformatf("hrdata at %h", addr), hrdata, exp);
    // IDLE cycle after a write
    else @(posedge clk);
  endtask

  task automatic watch_txd(output logic [7:0] data);
    int n;
    n = 0;
    data = 8'h00;
    while (txd !== 1'b0 && n < 2 * BAUD_DIV) begin
      @(negedge clk);
      n++;
    end
    if (txd !== 1'b0) begin
      errors++;
      $display("No start bit appeared on txd after the transmit write");
      return;
    end
    repeat (BAUD_DIV / 2) @(negedge clk);
    check_val("txd start bit", {31'h0, txd}, 32'h0);
    for (int i = 0; i < 8; i++) begin
      repeat (BAUD_DIV) @(negedge clk);
      data[i] = txd;
    end
    repeat (BAUD_DIV) @(negedge clk);
    check_val("txd stop bit", {31'h0, txd}, 32'h1);
  endtask

  task automatic drive_rxd(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      rxd <= frame[i];
      repeat (BAUD_DIV - 1) @(posedge clk);
    end
  endtask

  task automatic test_uart_tx(input logic [7:0] data);
    logic [7:0] got;
    bus_xfer(1'b1, UART_BASE | 32'(UART_DATA_OFS), WORD, {24'h0, data}, 32'h0);
    bus_xfer(1'b0, UART_BASE | 32'(UART_STAT_OFS), WORD, 32'h0, 32'h1);
    watch_txd(got);
    check_val("txd frame", {24'h0, got}, {24'h0, data});
    // Busy clears one bit period after mid stop
    repeat (BAUD_DIV) @(posedge clk);
    bus_xfer(1'b0, UART_BASE | 32'(UART_STAT_OFS), WORD, 32'h0, 32'h0);
  endtask

  task automatic test_uart_rx(input logic [7:0] data);
    int irq_base;
    int n;
    irq_base = irq_cnt;
    n = 0;
    drive_rxd(data);
    while (irq_cnt == irq_base && n < 2 * BAUD_DIV) begin
      @(posedge clk);
      n++;
    end
    if (irq_cnt == irq_base) begin
      errors++;
      $display("No uart_irq pulse followed the received frame");
    end
    repeat (BAUD_DIV) @(posedge clk);
    check_val("uart_irq pulse count", 32'(irq_cnt - irq_base), 32'h1);
    bus_xfer(1'b0, UART_BASE | 32'(UART_DATA_OFS), WORD, 32'h0, {24'h0, data});
  endtask

  // ------------------------------------------------------------
  // Background monitors and timeout
  // ------------------------------------------------------------
  always @(negedge clk) begin
    if (RSTn && uart_irq) irq_cnt++;
    if (RSTn && hready !== 1'b1) begin
      errors++;
      $display("Fail hready: got %h, expected %h", hready, 1'b1);
    end
    if (RSTn && hresp !== 1'b0) begin
      errors++;
      $display("Fail hresp: got %h, expected %h", hresp, 1'b0);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout: the run went past %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    clk         = 1'b0;
    RSTn        = 1'b0;
    haddr       = 32'h0;
    htrans      = IDLE;
    hsize       = WORD;
    hwrite      = 1'b0;
    hwdata      = 32'h0;
    rxd         = 1'b1;
    errors      = 0;
    checks      = 0;
    irq_cnt     = 0;
    cycles      = 0;
    cycle_limit = 0;
    led_model   = 8'h00;
    void'($urandom(57077));
    build_table();
    tx_val = 8'($urandom);
    rx_val = 8'($urandom);
    // Table, two serial frames, then double for margin
    cycle_limit = 2 * (RESET_CYCLES + 4 * rows.size() + 2 * 15 * BAUD_DIV) + 100;

    repeat (RESET_CYCLES) @(posedge clk);
    RSTn <= 1'b1;
    @(negedge clk);
    check_val("led after reset", {24'h0, led}, 32'h0);
    check_val("txd after reset", {31'h0, txd}, 32'h1);

    foreach (rows[i]) bus_xfer(rows[i].wr, rows[i].addr, rows[i].size, rows[i].data, rows[i].exp);
    check_val("led", {24'h0, led}, {24'h0, led_model});

    test_uart_tx(tx_val);
    test_uart_rx(rx_val);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display("All tests passed");
    else $display("Some tests failed");
    $finish;
  end

endmodule

// File: uart_baud.sv
/* UART baud tick generator */

module uart_baud #(
  parameter int BAUD_DIV = 347
) (
  input  logic clk,
  input  logic RSTn,
  input  logic tx_req,
  input  logic rx_req,
  output logic tick
);

  localparam int CNT_W = $clog2(BAUD_DIV);

  logic [CNT_W-1:0] cnt;
  logic             active;

  assign active = tx_req || rx_req;

  // Held at zero while no side needs ticks
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) cnt <= '0;
    else if (!active) cnt <= '0;
    else if (cnt == CNT_W'(BAUD_DIV - 1)) cnt <= '0;
    else cnt <= cnt + 1'b1;
  end

  // Mid-bit strobe
  assign tick = active && (cnt == CNT_W'(BAUD_DIV / 2));

endmodule

// File: uart_rx.sv
/* UART 8N1 receiver */

module uart_rx (
  input  logic       clk,
  input  logic       RSTn,
  input  logic       rxd,
  input  logic       tick,
  output logic       rx_req,
  output logic [7:0] rx_byte,
  output logic       rx_done
);

  logic       rxd_s1;
  logic       rxd_s2;
  logic       rxd_d;
  logic       fall;
  logic [3:0] bit_cnt;
  logic [7:0] shreg;

  assign fall = rxd_d && !rxd_s2;

  // Two-flop synchronizer plus edge history
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      rxd_s1 <= 1'b1;
      rxd_s2 <= 1'b1;
      rxd_d  <= 1'b1;
    end else begin
      rxd_s1 <= rxd;
      rxd_s2 <= rxd_s1;
      rxd_d  <= rxd_s2;
    end
  end

  // ------------------------------------------------------------
  // Frame control, bit 0 is start, 1..8 data, 9 stop
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      rx_req  <= 1'b0;
      bit_cnt <= 4'd0;
      rx_byte <= 8'h00;
      rx_done <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      if (!rx_req) begin
        if (fall) begin
          rx_req  <= 1'b1;
          bit_cnt <= 4'd0;
        end
      end else if (tick) begin
        if (bit_cnt == 4'd0 && rxd_s2) begin
          // Glitch, not a start bit
          rx_req <= 1'b0;
        end else if (bit_cnt == 4'd9) begin
          rx_req <= 1'b0;
          if (rxd_s2) begin
            rx_byte <= shreg;
            rx_done <= 1'b1;
          end
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_req && tick && bit_cnt != 4'd0 && bit_cnt <= 4'd8) shreg <= {rxd_s2, shreg[7:1]};
  end

endmodule

// File: uart_tx.sv
/* UART 8N1 transmitter */

module uart_tx (
  input  logic       clk,
  input  logic       RSTn,
  input  logic       tick,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       tx_req,
  output logic       txd
);

  logic [9:0] shreg;
  logic [3:0] bit_cnt;
  logic       load;
  logic       shift;

  assign load   = !tx_busy && tx_start;
  assign shift  = tx_busy && tick && (bit_cnt != 4'd10);
  assign tx_req = tx_busy;

  // ------------------------------------------------------------
  // Frame control
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      tx_busy <= 1'b0;
      bit_cnt <= 4'd0;
      txd     <= 1'b1;
    end else if (load) begin
      tx_busy <= 1'b1;
      bit_cnt <= 4'd0;
    end else if (tx_busy && tick) begin
      if (bit_cnt == 4'd10) begin
        // Stop bit has run a full period
        tx_busy <= 1'b0;
        txd     <= 1'b1;
      end else begin
        txd     <= shreg[0];
        bit_cnt <= bit_cnt + 4'd1;
      end
    end
  end

  // Stop, data LSB first, start
  always_ff @(posedge clk) begin
    if (load) shreg <= {1'b1, tx_byte, 1'b0};
    else if (shift) shreg <= {1'b1, shreg[9:1]};
  end

endmodule
